// File: logic/stack_defs.svh
`ifndef STACK_DEFS_SVH
`define STACK_DEFS_SVH

// data path and memory sizes
`define WORD_W 8
`define ADDR_W 7

// pointer value of an empty stack, the stack grows toward address 0
`define STACK_BASE 7'd127

`define CMD_W 4

// command codes as they arrive on cmd
`define CMD_POP       4'b0010
`define CMD_SUB       4'b0110
`define CMD_CLEAR     4'b1010
`define CMD_ADDR_UP   4'b1110
`define CMD_PUSH      4'b0001
`define CMD_ADD       4'b0101
`define CMD_TOP       4'b1001
`define CMD_ADDR_DOWN 4'b1101

`endif

// File: logic/stack_pkg.sv
`include "stack_defs.svh"

package stack_pkg;

  typedef logic [`WORD_W-1:0] wordT;
  typedef logic [`ADDR_W-1:0] addrT;

  typedef enum logic [`CMD_W-1:0] {
    cmdPop      = `CMD_POP,
    cmdSub      = `CMD_SUB,
    cmdClear    = `CMD_CLEAR,
    cmdAddrUp   = `CMD_ADDR_UP,
    cmdPush     = `CMD_PUSH,
    cmdAdd      = `CMD_ADD,
    cmdTop      = `CMD_TOP,
    cmdAddrDown = `CMD_ADDR_DOWN
  } stackCmdT;

  // controller sequence states
  typedef enum logic [3:0] {
    stIdle,
    stClear,
    stPush,
    stPop,
    stTop,
    stAddrUp,
    stAddrDown,
    stRead,     // present display address to the ram
    stLoad,     // read word into display value
    stArith1,
    stArith2,
    stArith3,
    stArith4,
    stArith5,
    stArith6
  } ctrlStateT;

  typedef enum logic [1:0] {sprHold, sprBase, sprInc, sprDec} sprSelT;

  typedef enum logic [2:0] {
    darHold, darClear, darUp, darDown, darPtr, darPtrPlus1
  } darSelT;

  typedef enum logic [1:0] {addrDisp, addrPtr, addrPtrPlus1} addrSelT;

  typedef enum logic [1:0] {dvrHold, dvrMem, dvrArith, dvrClear} dvrSelT;

endpackage

// File: logic/stackControl.sv
`timescale 1ns/100ps

module stackControl import stack_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  stackCmdT  cmd,
  output logic      busy,
  output sprSelT    sprSel,
  output darSelT    darSel,
  output addrSelT   addrSel,
  output dvrSelT    dvrSel,
  output logic      memWe,
  output logic      opSub,
  output logic      op1En,
  output logic      op2En
);

  ctrlStateT state;
  ctrlStateT nextState;
  logic      subOp; // add and subtract share one sequence

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
      subOp <= 1'b0;
    end else begin
      state <= nextState;
      if (state == stIdle) begin
        subOp <= (cmd == cmdSub); // last idle cycle decides
      end
    end
  end

  // sequencing, cmd only looked at while idle
  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        case (cmd)
          cmdPush:        nextState = stPush;
          cmdPop:         nextState = stPop;
          cmdAdd, cmdSub: nextState = stArith1;
          cmdTop:         nextState = stTop;
          cmdClear:       nextState = stClear;
          cmdAddrUp:      nextState = stAddrUp;
          cmdAddrDown:    nextState = stAddrDown;
          default:        nextState = stIdle; // unknown codes dropped
        endcase
      end
      stClear:    nextState = stIdle;
      stPush:     nextState = stRead; // read back what was written
      stPop:      nextState = stTop;  // pop then show the new top
      stTop:      nextState = stRead;
      stAddrUp:   nextState = stRead;
      stAddrDown: nextState = stRead;
      stRead:     nextState = stLoad;
      stLoad:     nextState = stIdle;
      stArith1:   nextState = stArith2;
      stArith2:   nextState = stArith3;
      stArith3:   nextState = stArith4;
      stArith4:   nextState = stArith5;
      stArith5:   nextState = stArith6;
      stArith6:   nextState = stIdle;
      default:    nextState = stIdle;
    endcase
  end

  // Moore outputs, everything idles unless a state asks for it
  always_comb begin
    sprSel  = sprHold;
    darSel  = darHold;
    addrSel = addrDisp;
    dvrSel  = dvrHold;
    memWe   = 1'b0;
    op1En   = 1'b0;
    op2En   = 1'b0;
    case (state)
      stClear: begin
        sprSel = sprBase;
        darSel = darClear;
        dvrSel = dvrClear;
      end
      stPush: begin
        // switches go to the free slot, pointer moves below it
        memWe   = 1'b1;
        addrSel = addrPtr;
        darSel  = darPtr;
        sprSel  = sprDec;
      end
      stPop: begin
        sprSel = sprInc;
      end
      stTop: begin
        darSel = darPtrPlus1; // top entry sits just above the pointer
      end
      stAddrUp: begin
        darSel = darUp;
      end
      stAddrDown: begin
        darSel = darDown;
      end
      stRead: begin
        addrSel = addrDisp;
      end
      stLoad: begin
        dvrSel = dvrMem;
      end
      stArith1: begin
        sprSel = sprInc; // pointer onto the top entry
      end
      stArith2: begin
        addrSel = addrPtr; // fetch top
      end
      stArith3: begin
        op1En   = 1'b1;
        addrSel = addrPtrPlus1; // fetch next
      end
      stArith4: begin
        op2En  = 1'b1;
        sprSel = sprInc; // pointer onto the next entry
      end
      stArith5: begin
        // result overwrites the next entry and is shown at once
        memWe   = 1'b1;
        addrSel = addrPtr;
        darSel  = darPtr;
        dvrSel  = dvrArith;
      end
      stArith6: begin
        sprSel = sprDec; // back to the free slot above... below the result
      end
      default: begin
      end
    endcase
  end

  assign busy  = (state != stIdle);
  assign opSub = subOp;

endmodule

// File: logic/pointerUnit.sv
`timescale 1ns/100ps

`include "stack_defs.svh"

module pointerUnit import stack_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  sprSelT  sprSel,
  input  darSelT  darSel,
  input  addrSelT addrSel,
  output addrT    memAddr,
  output addrT    dispAddr,
  output logic    empty
);

  addrT spr;      // next free slot
  addrT sprPlus1; // current top entry
  addrT sprNext;
  addrT darNext;

  assign sprPlus1 = spr + addrT'(1);

  always_comb begin
    case (sprSel)
      sprBase: sprNext = `STACK_BASE;
      sprInc:  sprNext = sprPlus1;
      sprDec:  sprNext = spr - addrT'(1); // wraps below 0, no guard
      default: sprNext = spr;
    endcase
  end

  always_comb begin
    case (darSel)
      darClear:    darNext = '0;
      darUp:       darNext = dispAddr + addrT'(1);
      darDown:     darNext = dispAddr - addrT'(1);
      darPtr:      darNext = spr;
      darPtrPlus1: darNext = sprPlus1;
      default:     darNext = dispAddr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      spr      <= `STACK_BASE;
      dispAddr <= '0;
    end else begin
      spr      <= sprNext;
      dispAddr <= darNext;
    end
  end

  always_comb begin
    case (addrSel)
      addrPtr:      memAddr = spr;
      addrPtrPlus1: memAddr = sprPlus1;
      default:      memAddr = dispAddr;
    endcase
  end

  assign empty = &spr; // pointer back at the base

endmodule

// File: logic/valueUnit.sv
`timescale 1ns/100ps

module valueUnit import stack_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  wordT   rdData,
  input  wordT   swtchs,
  input  dvrSelT dvrSel,
  input  logic   op1En,
  input  logic   op2En,
  input  logic   opSub,
  output wordT   wrData,
  output wordT   dispValue
);

  wordT op1;    // top entry
  wordT op2;    // entry below the top
  wordT result;
  wordT dvrNext;

  always_ff @(posedge clk) begin
    if (op1En) begin
      op1 <= rdData;
    end
    if (op2En) begin
      op2 <= rdData;
    end
  end

  // modulo 256, top entry always on the left
  assign result = opSub ? (op1 - op2) : (op1 + op2);

  always_comb begin
    case (dvrSel)
      dvrMem:   dvrNext = rdData;
      dvrArith: dvrNext = result;
      dvrClear: dvrNext = '0;
      default:  dvrNext = dispValue;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dispValue <= '0;
    end else begin
      dispValue <= dvrNext;
    end
  end

  // arithmetic writes are the ones that also show the result,
  // every other write is a push of the switches
  assign wrData = (dvrSel == dvrArith) ? result : swtchs;

endmodule

// File: logic/stackRam.sv
`timescale 1ns/100ps

`include "stack_defs.svh"

module stackRam import stack_pkg::*; (
  input  logic clk,
  input  logic we,
  input  addrT addr,
  input  wordT wrData,
  output wordT rdData
);

  localparam int Depth = 1 << `ADDR_W;

  wordT mem [0:Depth-1];

  // registered read, old word comes out when reading a location being written
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wrData;
    end
    rdData <= mem[addr];
  end

endmodule

// File: logic/stackCalc.sv
`timescale 1ns/100ps

module stackCalc import stack_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  stackCmdT cmd,
  input  wordT     swtchs,
  output wordT     leds,
  output wordT     dispValue,
  output logic     busy
);

  sprSelT  sprSel;
  darSelT  darSel;
  addrSelT addrSel;
  dvrSelT  dvrSel;
  logic    memWe;
  logic    opSub;
  logic    op1En;
  logic    op2En;
  addrT    memAddr;
  addrT    dispAddr;
  logic    empty;
  wordT    rdData;
  wordT    wrData;

  stackControl stackControl_i (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .busy    (busy),
    .sprSel  (sprSel),
    .darSel  (darSel),
    .addrSel (addrSel),
    .dvrSel  (dvrSel),
    .memWe   (memWe),
    .opSub   (opSub),
    .op1En   (op1En),
    .op2En   (op2En)
  );

  pointerUnit pointerUnit_i (
    .clk      (clk),
    .reset    (reset),
    .sprSel   (sprSel),
    .darSel   (darSel),
    .addrSel  (addrSel),
    .memAddr  (memAddr),
    .dispAddr (dispAddr),
    .empty    (empty)
  );

  valueUnit valueUnit_i (
    .clk       (clk),
    .reset     (reset),
    .rdData    (rdData),
    .swtchs    (swtchs),
    .dvrSel    (dvrSel),
    .op1En     (op1En),
    .op2En     (op2En),
    .opSub     (opSub),
    .wrData    (wrData),
    .dispValue (dispValue)
  );

  stackRam stackRam_i (
    .clk    (clk),
    .we     (memWe),
    .addr   (memAddr),
    .wrData (wrData),
    .rdData (rdData)
  );

  assign leds = {empty, dispAddr}; // empty flag on the top led

endmodule

// File: tests/stackChecker.sv
`timescale 1ns/100ps

`include "stack_defs.svh"

module stackChecker import stack_pkg::*; (
  input logic clk,
  input logic busy,
  input wordT leds,
  input wordT dispValue
);

  int passCount = 0;
  int failCount = 0;
  int opsDone   = 0; // completed operations seen on the ports
  logic busyLast = 1'b0;

  // outputs only move on rising edges, so the falling edge sees them settled
  always @(negedge clk) begin
    if (busyLast === 1'b1 && busy === 1'b0) begin
      opsDone <= opsDone + 1;
    end
    busyLast <= busy;
  end

  // called once busy has been seen low again
  task automatic compareEntry(input string name, input wordT expValue,
                              input addrT expAddr, input logic expEmpty);
    string diffs;
    addrT  gotAddr;
    logic  gotEmpty;
    diffs    = "";
    gotAddr  = leds[`ADDR_W-1:0];  // display address below the empty led
    gotEmpty = leds[`WORD_W-1];
    if (dispValue !== expValue) begin
      diffs = {diffs, $sformatf(" dispValue %02h expected %02h", dispValue, expValue)};
    end
    if (gotAddr !== expAddr) begin
      diffs = {diffs, $sformatf(" dispAddr %0d expected %0d", gotAddr, expAddr)};
    end
    if (gotEmpty !== expEmpty) begin
      diffs = {diffs, $sformatf(" empty %b expected %b", gotEmpty, expEmpty)};
    end
    if (diffs == "") begin
      passCount++;
      $display("ok     %s", name);
    end else begin
      failCount++;
      $display("** Error at %0t ns: %s,%s", $time, name, diffs);
    end
  endtask

  // one busy pulse per command issued
  task automatic compareOpCount(input int expOps);
    if (opsDone != expOps) begin
      failCount++;
      $display("** Error at %0t ns: %0d operations seen, expected %0d",
               $time, opsDone, expOps);
    end
  endtask

endmodule

// File: tests/stackCalcTb.sv
`timescale 1ns/100ps

`include "stack_defs.svh"

module stackCalcTb import stack_pkg::*; ();

  localparam int TimeoutCycles = 50;

  logic     clk = 1'b0;
  logic     reset;
  stackCmdT cmd;
  wordT     swtchs;
  wordT     leds;
  wordT     dispValue;
  logic     busy;

  // stimulus table, a command code of 0 means check only
  logic [`CMD_W-1:0] rowCmd[$];
  wordT              rowSw[$];
  wordT              rowValue[$];
  addrT              rowAddr[$];
  logic              rowEmpty[$];
  string             rowName[$];

  bit timedOut = 1'b0;

  always #2 clk = ~clk;

  stackCalc stackCalc_i (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .swtchs    (swtchs),
    .leds      (leds),
    .dispValue (dispValue),
    .busy      (busy)
  );

  stackChecker stackChecker_i (
    .clk       (clk),
    .busy      (busy),
    .leds      (leds),
    .dispValue (dispValue)
  );

  task automatic addRow(input logic [`CMD_W-1:0] code, input wordT sw, input wordT value,
                        input addrT addr, input logic emp, input string name);
    rowCmd.push_back(code);
    rowSw.push_back(sw);
    rowValue.push_back(value);
    rowAddr.push_back(addr);
    rowEmpty.push_back(emp);
    rowName.push_back(name);
  endtask

  // stack grows down from 127, results land one above the old top
  task automatic buildTable();
    wordT a, b, c, d, e, f, g;
    wordT s1, s2, s3;
    a  = wordT'($urandom);
    b  = wordT'($urandom);
    c  = wordT'($urandom);
    d  = wordT'($urandom);
    e  = wordT'($urandom);
    f  = wordT'($urandom);
    g  = wordT'($urandom);
    s1 = c + b;  // top plus next
    s2 = d - s1; // top minus next
    s3 = f - s2;
    addRow(4'b0000, 8'h00, 8'h00, 7'd0, 1'b1, "reset state");
    addRow(`CMD_PUSH, a, a, 7'd127, 1'b0, "push a");
    addRow(`CMD_PUSH, b, b, 7'd126, 1'b0, "push b");
    addRow(`CMD_PUSH, c, c, 7'd125, 1'b0, "push c");
    addRow(`CMD_ADD, c, s1, 7'd126, 1'b0, "add c b");
    addRow(`CMD_PUSH, d, d, 7'd125, 1'b0, "push d");
    addRow(`CMD_SUB, d, s2, 7'd126, 1'b0, "sub d sum");
    addRow(`CMD_ADDR_UP, d, a, 7'd127, 1'b0, "address up before top");
    addRow(`CMD_TOP, d, s2, 7'd126, 1'b0, "top after sub");
    addRow(`CMD_PUSH, e, e, 7'd125, 1'b0, "push e");
    addRow(`CMD_POP, e, s2, 7'd126, 1'b0, "pop e");
    addRow(`CMD_PUSH, f, f, 7'd125, 1'b0, "push f after pop");
    addRow(`CMD_ADDR_UP, f, s2, 7'd126, 1'b0, "address up 126");
    addRow(`CMD_ADDR_UP, f, a, 7'd127, 1'b0, "address up 127");
    addRow(`CMD_ADDR_DOWN, f, s2, 7'd126, 1'b0, "address down 126");
    addRow(`CMD_ADDR_DOWN, f, f, 7'd125, 1'b0, "address down 125");
    addRow(`CMD_SUB, f, s3, 7'd126, 1'b0, "sub f diff");
    addRow(`CMD_CLEAR, f, 8'h00, 7'd0, 1'b1, "clear");
    addRow(`CMD_PUSH, g, g, 7'd127, 1'b0, "push g after clear");
    addRow(`CMD_TOP, g, g, 7'd127, 1'b0, "top g");
    addRow(`CMD_PUSH, 8'hf0, 8'hf0, 7'd126, 1'b0, "push f0");
    addRow(`CMD_PUSH, 8'h30, 8'h30, 7'd125, 1'b0, "push 30");
    addRow(`CMD_ADD, 8'h30, 8'h20, 7'd126, 1'b0, "add wraps");
    addRow(`CMD_PUSH, 8'h05, 8'h05, 7'd125, 1'b0, "push 05");
    addRow(`CMD_SUB, 8'h05, 8'he5, 7'd126, 1'b0, "sub wraps");
    addRow(`CMD_POP, 8'h05, g, 7'd127, 1'b0, "pop to g");
    addRow(`CMD_ADDR_DOWN, 8'h05, 8'he5, 7'd126, 1'b0, "address down to result");
  endtask

  // polls on falling edges until busy reaches level
  task automatic waitForBusy(input logic level, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TimeoutCycles && !ok; n++) begin
      @(negedge clk);
      if (busy === level) ok = 1'b1;
    end
  endtask

  initial begin
    int i;
    int cmdCount;
    bit ok;
    reset    = 1'b1;
    cmd      = stackCmdT'(4'b0000);
    swtchs   = '0;
    cmdCount = 0;
    void'($urandom(4221));
    buildTable();
    repeat (4) @(negedge clk);
    reset = 1'b0;
    for (i = 0; i < rowCmd.size(); i++) begin
      if (rowCmd[i] != '0) begin
        cmdCount++;
        cmd    = stackCmdT'(rowCmd[i]);
        swtchs = rowSw[i];
        waitForBusy(1'b1, ok);
        cmd = stackCmdT'(4'b0000); // one cycle of command is enough
        if (!ok) begin
          $display("busy never went high for test %s", rowName[i]);
          timedOut = 1'b1;
          break;
        end
        waitForBusy(1'b0, ok);
        if (!ok) begin
          $display("busy stayed high too long in test %s", rowName[i]);
          timedOut = 1'b1;
          break;
        end
      end
      stackChecker_i.compareEntry(rowName[i], rowValue[i], rowAddr[i], rowEmpty[i]);
    end
    @(negedge clk); // let the last busy fall reach the operation count
    stackChecker_i.compareOpCount(cmdCount);
    $display("tests passed %0d, failed %0d, operations seen %0d",
             stackChecker_i.passCount, stackChecker_i.failCount, stackChecker_i.opsDone);
    if (timedOut || stackChecker_i.failCount != 0) begin
      $display("RESULT: FAIL");
    end else begin
      $display("RESULT: PASS");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+logic
logic/stack_pkg.sv
logic/stackControl.sv
logic/pointerUnit.sv
logic/valueUnit.sv
logic/stackRam.sv
logic/stackCalc.sv
tests/stackChecker.sv
tests/stackCalcTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f flist.f --top-module stackCalcTb --Mdir obj_dir -o simv
	./obj_dir/simv > sim.log
	cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
